// ==== verilog/core_cfg_pkg.sv ====
`default_nettype none

package core_cfg_pkg;

    localparam int num_regs  = 16;
    localparam int rob_depth = 8;
    localparam int rs_depth  = 3;
    localparam int word_w    = 16;

    // data and register numbers
    typedef logic [word_w-1:0]            word_t;
    typedef logic [$clog2(num_regs)-1:0]  reg_idx_t;

    // tags name a reorder-buffer slot, count needs one more bit
    typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;
    typedef logic [$clog2(rob_depth):0]   rob_count_t;

    // entry index inside one station
    typedef logic [$clog2(rs_depth)-1:0]  rs_idx_t;

endpackage

`default_nettype wire

// ==== verilog/op_pkg.sv ====
`default_nettype none

package op_pkg;

    typedef logic [3:0] func_t;

    localparam func_t fn_add  = 4'd0;
    localparam func_t fn_sub  = 4'd1;
    localparam func_t fn_mul  = 4'd2;
    localparam func_t fn_mulh = 4'd3;

    typedef enum logic [1:0] {unit_add, unit_mul, unit_bch} unit_e;

    // codes 4 and up are branch compares
    function automatic unit_e unit_of(input func_t f);
        if (f == fn_add || f == fn_sub)
            return unit_add;
        if (f == fn_mul || f == fn_mulh)
            return unit_mul;
        return unit_bch;
    endfunction

    function automatic logic writes_reg(input func_t f);
        return unit_of(f) != unit_bch;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/dispatch_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface dispatch_if;
    import core_cfg_pkg::*;
    import op_pkg::*;

    logic     valid;
    func_t    func;
    reg_idx_t rd;
    rob_idx_t tag;

    // each source is either a value or the tag it waits for
    logic     src1_rdy;
    word_t    src1_val;
    rob_idx_t src1_tag;
    logic     src2_rdy;
    word_t    src2_val;
    rob_idx_t src2_tag;

    modport issue (
        output valid, func, rd, tag,
        output src1_rdy, src1_val, src1_tag,
        output src2_rdy, src2_val, src2_tag
    );

    modport station (
        input valid, func, rd, tag,
        input src1_rdy, src1_val, src1_tag,
        input src2_rdy, src2_val, src2_tag
    );

endinterface

`default_nettype wire

// ==== verilog/register_status.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_status (
    input  wire                          clk1,
    input  wire                          rst,
    input  wire  core_cfg_pkg::reg_idx_t rs1,
    input  wire  core_cfg_pkg::reg_idx_t rs2,
    output logic                         src1_busy,
    output logic                         src2_busy,
    output core_cfg_pkg::rob_idx_t       src1_tag,
    output core_cfg_pkg::rob_idx_t       src2_tag,
    output core_cfg_pkg::word_t          src1_val,
    output core_cfg_pkg::word_t          src2_val,
    input  wire                          alloc_en,
    input  wire  core_cfg_pkg::reg_idx_t alloc_rd,
    input  wire  core_cfg_pkg::rob_idx_t alloc_tag,
    input  wire                          ret_en,
    input  wire  core_cfg_pkg::reg_idx_t ret_rd,
    input  wire  core_cfg_pkg::rob_idx_t ret_tag,
    input  wire  core_cfg_pkg::word_t    ret_value
);
    import core_cfg_pkg::*;

    word_t               regs [num_regs];
    rob_idx_t            tag  [num_regs];
    logic [num_regs-1:0] busy;

    assign src1_busy = busy[rs1];
    assign src2_busy = busy[rs2];
    assign src1_tag  = tag[rs1];
    assign src2_tag  = tag[rs2];
    assign src1_val  = regs[rs1];
    assign src2_val  = regs[rs2];

    always_ff @(posedge clk1)
    begin
        if (rst)
        begin
            busy <= '0;
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end
        else
        begin
            // an older writer retiring behind a newer one leaves the register alone
            if (ret_en && busy[ret_rd] && tag[ret_rd] == ret_tag)
            begin
                regs[ret_rd] <= ret_value;
                busy[ret_rd] <= 1'b0;
            end
            // later assignment so a same-edge issue keeps busy and tag
            if (alloc_en)
            begin
                busy[alloc_rd] <= 1'b1;
                tag[alloc_rd]  <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/reorder_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer (
    input  wire                          clk1,
    input  wire                          rst,
    input  wire                          alloc_en,
    input  wire  op_pkg::func_t          alloc_func,
    input  wire  core_cfg_pkg::reg_idx_t alloc_rd,
    output core_cfg_pkg::rob_idx_t       tail,
    output logic                         full,
    input  wire  core_cfg_pkg::rob_idx_t q1_tag,
    input  wire  core_cfg_pkg::rob_idx_t q2_tag,
    output logic                         q1_done,
    output logic                         q2_done,
    output core_cfg_pkg::word_t          q1_val,
    output core_cfg_pkg::word_t          q2_val,
    input  wire                          cdb_valid,
    input  wire  core_cfg_pkg::rob_idx_t cdb_tag,
    input  wire  core_cfg_pkg::word_t    cdb_value,
    output logic                         commit_valid,
    output core_cfg_pkg::rob_idx_t       commit_tag,
    output core_cfg_pkg::reg_idx_t       commit_rd,
    output core_cfg_pkg::word_t          commit_value,
    output logic                         commit_wr
);
    import core_cfg_pkg::*;
    import op_pkg::*;

    func_t                func  [rob_depth];
    reg_idx_t             rd    [rob_depth];
    word_t                value [rob_depth];
    logic [rob_depth-1:0] done;
    rob_idx_t             head;
    rob_count_t           count;

    assign full = count == rob_count_t'(rob_depth);

    // operand lookups from the issue stage
    assign q1_done = done[q1_tag];
    assign q2_done = done[q2_tag];
    assign q1_val  = value[q1_tag];
    assign q2_val  = value[q2_tag];

    // retire the oldest entry once its result is in
    assign commit_valid = count != '0 && done[head];
    assign commit_tag   = head;
    assign commit_rd    = rd[head];
    assign commit_value = value[head];
    assign commit_wr    = writes_reg(func[head]);

    always_ff @(posedge clk1)
    begin
        if (rst)
        begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end
        else
        begin
            if (cdb_valid)
            begin
                done[cdb_tag]  <= 1'b1;
                value[cdb_tag] <= cdb_value;
            end
            if (commit_valid)
                head <= head + 1'b1;
            if (alloc_en)
            begin
                func[tail] <= alloc_func;
                rd[tail]   <= alloc_rd;
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            count <= count + rob_count_t'(alloc_en) - rob_count_t'(commit_valid);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/issue_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_stage (
    input  wire                          in_valid,
    input  wire  op_pkg::func_t          in_func,
    input  wire  core_cfg_pkg::reg_idx_t in_rd,
    input  wire  core_cfg_pkg::reg_idx_t in_rs1,
    input  wire  core_cfg_pkg::reg_idx_t in_rs2,
    output logic                         stall,
    output core_cfg_pkg::reg_idx_t       rs1,
    output core_cfg_pkg::reg_idx_t       rs2,
    input  wire                          src1_busy,
    input  wire                          src2_busy,
    input  wire  core_cfg_pkg::rob_idx_t src1_tag,
    input  wire  core_cfg_pkg::rob_idx_t src2_tag,
    input  wire  core_cfg_pkg::word_t    src1_val,
    input  wire  core_cfg_pkg::word_t    src2_val,
    output core_cfg_pkg::rob_idx_t       q1_tag,
    output core_cfg_pkg::rob_idx_t       q2_tag,
    input  wire                          q1_done,
    input  wire                          q2_done,
    input  wire  core_cfg_pkg::word_t    q1_val,
    input  wire  core_cfg_pkg::word_t    q2_val,
    output logic                         alloc_en,
    input  wire  core_cfg_pkg::rob_idx_t rob_tail,
    input  wire                          rob_full,
    input  wire                          add_free,
    input  wire                          mul_free,
    input  wire                          bch_free,
    input  wire                          cdb_valid,
    input  wire  core_cfg_pkg::rob_idx_t cdb_tag,
    input  wire  core_cfg_pkg::word_t    cdb_value,
    dispatch_if.issue                    disp_add,
    dispatch_if.issue                    disp_mul,
    dispatch_if.issue                    disp_bch
);
    import core_cfg_pkg::*;
    import op_pkg::*;

    unit_e unit;
    logic  class_free;
    logic  op1_rdy;
    logic  op2_rdy;
    word_t op1_val;
    word_t op2_val;

    // register value, then finished buffer entry, then this cycle's bus
    function automatic void resolve(
        input  logic  busy,
        input  word_t reg_val,
        input  logic  done,
        input  word_t rob_val,
        input  logic  bus_hit,
        input  word_t bus_val,
        output logic  rdy,
        output word_t val
    );
        rdy = 1'b1;
        val = reg_val;
        if (busy)
        begin
            if (done)
                val = rob_val;
            else if (bus_hit)
                val = bus_val;
            else
                rdy = 1'b0;
        end
    endfunction

    assign rs1    = in_rs1;
    assign rs2    = in_rs2;
    assign q1_tag = src1_tag;
    assign q2_tag = src2_tag;

    assign unit = unit_of(in_func);

    always_comb
    begin
        case (unit)
            unit_add: class_free = add_free;
            unit_mul: class_free = mul_free;
            default:  class_free = bch_free;
        endcase
    end

    assign stall    = rob_full || !class_free;
    assign alloc_en = in_valid && !stall;

    always_comb
    begin
        resolve(src1_busy, src1_val, q1_done, q1_val,
                cdb_valid && cdb_tag == src1_tag, cdb_value, op1_rdy, op1_val);
        resolve(src2_busy, src2_val, q2_done, q2_val,
                cdb_valid && cdb_tag == src2_tag, cdb_value, op2_rdy, op2_val);
    end

    // only the class of the instruction sees a strobe
    assign disp_add.valid = alloc_en && unit == unit_add;
    assign disp_mul.valid = alloc_en && unit == unit_mul;
    assign disp_bch.valid = alloc_en && unit == unit_bch;

    assign disp_add.func     = in_func;
    assign disp_add.rd       = in_rd;
    assign disp_add.tag      = rob_tail;
    assign disp_add.src1_rdy = op1_rdy;
    assign disp_add.src1_val = op1_val;
    assign disp_add.src1_tag = src1_tag;
    assign disp_add.src2_rdy = op2_rdy;
    assign disp_add.src2_val = op2_val;
    assign disp_add.src2_tag = src2_tag;

    assign disp_mul.func     = in_func;
    assign disp_mul.rd       = in_rd;
    assign disp_mul.tag      = rob_tail;
    assign disp_mul.src1_rdy = op1_rdy;
    assign disp_mul.src1_val = op1_val;
    assign disp_mul.src1_tag = src1_tag;
    assign disp_mul.src2_rdy = op2_rdy;
    assign disp_mul.src2_val = op2_val;
    assign disp_mul.src2_tag = src2_tag;

    assign disp_bch.func     = in_func;
    assign disp_bch.rd       = in_rd;
    assign disp_bch.tag      = rob_tail;
    assign disp_bch.src1_rdy = op1_rdy;
    assign disp_bch.src1_val = op1_val;
    assign disp_bch.src1_tag = src1_tag;
    assign disp_bch.src2_rdy = op2_rdy;
    assign disp_bch.src2_val = op2_val;
    assign disp_bch.src2_tag = src2_tag;

endmodule

`default_nettype wire

// ==== verilog/reservation_station.sv ====
`timescale 1ns/1ns
`default_nettype none

module reservation_station #(
    parameter op_pkg::unit_e unit_class = op_pkg::unit_add
) (
    input  wire                          clk1,
    input  wire                          rst,
    dispatch_if.station                  disp,
    output logic                         free,
    input  wire                          cdb_valid,
    input  wire  core_cfg_pkg::rob_idx_t cdb_tag,
    input  wire  core_cfg_pkg::word_t    cdb_value,
    output logic                         ex_valid,
    output op_pkg::func_t                ex_func,
    output core_cfg_pkg::word_t          ex_a,
    output core_cfg_pkg::word_t          ex_b,
    output core_cfg_pkg::rob_idx_t       ex_tag,
    input  wire                          ex_grant
);
    import core_cfg_pkg::*;
    import op_pkg::*;

    logic [rs_depth-1:0] busy;
    logic [rs_depth-1:0] a_rdy;
    logic [rs_depth-1:0] b_rdy;
    logic [rs_depth-1:0] ready;
    func_t               func  [rs_depth];
    rob_idx_t            tag   [rs_depth];
    word_t               a_val [rs_depth];
    word_t               b_val [rs_depth];
    rob_idx_t            a_tag [rs_depth];
    rob_idx_t            b_tag [rs_depth];

    logic    take;
    logic    held;
    rs_idx_t held_idx;
    rs_idx_t sel;
    rs_idx_t fill;

    assign take  = disp.valid && unit_of(disp.func) == unit_class;
    assign free  = ~&busy;
    assign ready = busy & a_rdy & b_rdy;

    // lowest free slot
    always_comb
    begin
        fill = '0;
        for (int i = rs_depth - 1; i >= 0; i--)
        begin
            if (!busy[i])
                fill = rs_idx_t'(i);
        end
    end

    // a withheld offer stays put, else the lowest ready entry
    always_comb
    begin
        sel      = held_idx;
        ex_valid = held;
        if (!held)
        begin
            for (int i = rs_depth - 1; i >= 0; i--)
            begin
                if (ready[i])
                begin
                    sel      = rs_idx_t'(i);
                    ex_valid = 1'b1;
                end
            end
        end
    end

    assign ex_func = func[sel];
    assign ex_a    = a_val[sel];
    assign ex_b    = b_val[sel];
    assign ex_tag  = tag[sel];

    always_ff @(posedge clk1)
    begin
        if (rst)
        begin
            busy <= '0;
            held <= 1'b0;
        end
        else
        begin
            held     <= ex_valid && !ex_grant;
            held_idx <= sel;
            // wakeup from the bus
            for (int i = 0; i < rs_depth; i++)
            begin
                if (busy[i] && !a_rdy[i] && cdb_valid && cdb_tag == a_tag[i])
                begin
                    a_rdy[i] <= 1'b1;
                    a_val[i] <= cdb_value;
                end
                if (busy[i] && !b_rdy[i] && cdb_valid && cdb_tag == b_tag[i])
                begin
                    b_rdy[i] <= 1'b1;
                    b_val[i] <= cdb_value;
                end
            end
            if (ex_valid && ex_grant)
                busy[sel] <= 1'b0;
            if (take)
            begin
                busy[fill]  <= 1'b1;
                func[fill]  <= disp.func;
                tag[fill]   <= disp.tag;
                a_rdy[fill] <= disp.src1_rdy;
                a_val[fill] <= disp.src1_val;
                a_tag[fill] <= disp.src1_tag;
                b_rdy[fill] <= disp.src2_rdy;
                b_val[fill] <= disp.src2_val;
                b_tag[fill] <= disp.src2_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tomasulo_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tomasulo_core (
    input  wire                          clk1,
    input  wire                          rst,
    input  wire                          in_valid,
    input  wire  op_pkg::func_t          in_func,
    input  wire  core_cfg_pkg::reg_idx_t in_rd,
    input  wire  core_cfg_pkg::reg_idx_t in_rs1,
    input  wire  core_cfg_pkg::reg_idx_t in_rs2,
    output logic                         stall,
    output logic                         ex_add_valid,
    output op_pkg::func_t                ex_add_func,
    output core_cfg_pkg::word_t          ex_add_a,
    output core_cfg_pkg::word_t          ex_add_b,
    output core_cfg_pkg::rob_idx_t       ex_add_tag,
    input  wire                          ex_add_grant,
    output logic                         ex_mul_valid,
    output op_pkg::func_t                ex_mul_func,
    output core_cfg_pkg::word_t          ex_mul_a,
    output core_cfg_pkg::word_t          ex_mul_b,
    output core_cfg_pkg::rob_idx_t       ex_mul_tag,
    input  wire                          ex_mul_grant,
    output logic                         ex_bch_valid,
    output op_pkg::func_t                ex_bch_func,
    output core_cfg_pkg::word_t          ex_bch_a,
    output core_cfg_pkg::word_t          ex_bch_b,
    output core_cfg_pkg::rob_idx_t       ex_bch_tag,
    input  wire                          ex_bch_grant,
    input  wire                          cdb_valid,
    input  wire  core_cfg_pkg::rob_idx_t cdb_tag,
    input  wire  core_cfg_pkg::word_t    cdb_value,
    output logic                         commit_valid,
    output core_cfg_pkg::rob_idx_t       commit_tag,
    output core_cfg_pkg::reg_idx_t       commit_rd,
    output core_cfg_pkg::word_t          commit_value,
    output logic                         commit_wr
);
    import core_cfg_pkg::*;
    import op_pkg::*;

    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     src1_busy;
    logic     src2_busy;
    rob_idx_t src1_tag;
    rob_idx_t src2_tag;
    word_t    src1_val;
    word_t    src2_val;
    rob_idx_t q1_tag;
    rob_idx_t q2_tag;
    logic     q1_done;
    logic     q2_done;
    word_t    q1_val;
    word_t    q2_val;
    logic     alloc_en;
    rob_idx_t rob_tail;
    logic     rob_full;
    logic     add_free;
    logic     mul_free;
    logic     bch_free;

    dispatch_if disp_add ();
    dispatch_if disp_mul ();
    dispatch_if disp_bch ();

    // branches get a buffer slot but never claim a register
    register_status u_register_status (
        .clk1      (clk1),
        .rst       (rst),
        .rs1       (rs1),
        .rs2       (rs2),
        .src1_busy (src1_busy),
        .src2_busy (src2_busy),
        .src1_tag  (src1_tag),
        .src2_tag  (src2_tag),
        .src1_val  (src1_val),
        .src2_val  (src2_val),
        .alloc_en  (alloc_en && writes_reg(in_func)),
        .alloc_rd  (in_rd),
        .alloc_tag (rob_tail),
        .ret_en    (commit_valid && commit_wr),
        .ret_rd    (commit_rd),
        .ret_tag   (commit_tag),
        .ret_value (commit_value)
    );

    reorder_buffer u_reorder_buffer (
        .clk1         (clk1),
        .rst          (rst),
        .alloc_en     (alloc_en),
        .alloc_func   (in_func),
        .alloc_rd     (in_rd),
        .tail         (rob_tail),
        .full         (rob_full),
        .q1_tag       (q1_tag),
        .q2_tag       (q2_tag),
        .q1_done      (q1_done),
        .q2_done      (q2_done),
        .q1_val       (q1_val),
        .q2_val       (q2_val),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .commit_wr    (commit_wr)
    );

    issue_stage u_issue_stage (
        .in_valid  (in_valid),
        .in_func   (in_func),
        .in_rd     (in_rd),
        .in_rs1    (in_rs1),
        .in_rs2    (in_rs2),
        .stall     (stall),
        .rs1       (rs1),
        .rs2       (rs2),
        .src1_busy (src1_busy),
        .src2_busy (src2_busy),
        .src1_tag  (src1_tag),
        .src2_tag  (src2_tag),
        .src1_val  (src1_val),
        .src2_val  (src2_val),
        .q1_tag    (q1_tag),
        .q2_tag    (q2_tag),
        .q1_done   (q1_done),
        .q2_done   (q2_done),
        .q1_val    (q1_val),
        .q2_val    (q2_val),
        .alloc_en  (alloc_en),
        .rob_tail  (rob_tail),
        .rob_full  (rob_full),
        .add_free  (add_free),
        .mul_free  (mul_free),
        .bch_free  (bch_free),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .disp_add  (disp_add.issue),
        .disp_mul  (disp_mul.issue),
        .disp_bch  (disp_bch.issue)
    );

    reservation_station #(.unit_class(unit_add)) u_rs_add (
        .clk1      (clk1),
        .rst       (rst),
        .disp      (disp_add.station),
        .free      (add_free),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .ex_valid  (ex_add_valid),
        .ex_func   (ex_add_func),
        .ex_a      (ex_add_a),
        .ex_b      (ex_add_b),
        .ex_tag    (ex_add_tag),
        .ex_grant  (ex_add_grant)
    );

    reservation_station #(.unit_class(unit_mul)) u_rs_mul (
        .clk1      (clk1),
        .rst       (rst),
        .disp      (disp_mul.station),
        .free      (mul_free),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .ex_valid  (ex_mul_valid),
        .ex_func   (ex_mul_func),
        .ex_a      (ex_mul_a),
        .ex_b      (ex_mul_b),
        .ex_tag    (ex_mul_tag),
        .ex_grant  (ex_mul_grant)
    );

    reservation_station #(.unit_class(unit_bch)) u_rs_bch (
        .clk1      (clk1),
        .rst       (rst),
        .disp      (disp_bch.station),
        .free      (bch_free),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .ex_valid  (ex_bch_valid),
        .ex_func   (ex_bch_func),
        .ex_a      (ex_bch_a),
        .ex_b      (ex_bch_b),
        .ex_tag    (ex_bch_tag),
        .ex_grant  (ex_bch_grant)
    );

endmodule

`default_nettype wire

// ==== sim/tomasulo_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module tomasulo_tb;
    import core_cfg_pkg::*;
    import op_pkg::*;

    localparam int n_instr    = 300;
    localparam int n_seed     = 8;
    localparam int max_cycles = n_instr * 13 + 100;

    logic     clk1;
    logic     rst;
    logic     in_valid;
    func_t    in_func;
    reg_idx_t in_rd;
    reg_idx_t in_rs1;
    reg_idx_t in_rs2;
    logic     stall;
    logic     cdb_valid;
    rob_idx_t cdb_tag;
    word_t    cdb_value;
    logic     commit_valid;
    rob_idx_t commit_tag;
    reg_idx_t commit_rd;
    word_t    commit_value;
    logic     commit_wr;

    // execute ports indexed 0 add, 1 mul, 2 branch
    logic     ex_valid [3];
    func_t    ex_func  [3];
    word_t    ex_a     [3];
    word_t    ex_b     [3];
    rob_idx_t ex_tag   [3];
    logic     ex_grant [3];

    logic [31:0] seed = 32'ha810d858;
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          generated = 0;
    int          issued = 0;
    int          retired = 0;
    int          st_cnt [3] = '{0, 0, 0};

    // instruction waiting at the input
    logic     have_cur = 1'b0;
    func_t    cur_func;
    reg_idx_t cur_rd;
    reg_idx_t cur_rs1;
    reg_idx_t cur_rs2;
    word_t    cur_salt;

    // reference model of registers in program order and per-tag records
    word_t    model_regs [num_regs] = '{default: '0};
    func_t    t_func     [rob_depth];
    reg_idx_t t_rd       [rob_depth];
    word_t    t_a        [rob_depth];
    word_t    t_b        [rob_depth];
    word_t    t_res      [rob_depth];
    word_t    t_salt     [rob_depth];
    logic     t_granted  [rob_depth];

    // results in flight inside the modelled functional units
    rob_idx_t pend_tag [$];
    word_t    pend_val [$];
    int       pend_due [$];

    tomasulo_core u_tomasulo_core (
        .clk1         (clk1),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_func      (in_func),
        .in_rd        (in_rd),
        .in_rs1       (in_rs1),
        .in_rs2       (in_rs2),
        .stall        (stall),
        .ex_add_valid (ex_valid[0]),
        .ex_add_func  (ex_func[0]),
        .ex_add_a     (ex_a[0]),
        .ex_add_b     (ex_b[0]),
        .ex_add_tag   (ex_tag[0]),
        .ex_add_grant (ex_grant[0]),
        .ex_mul_valid (ex_valid[1]),
        .ex_mul_func  (ex_func[1]),
        .ex_mul_a     (ex_a[1]),
        .ex_mul_b     (ex_b[1]),
        .ex_mul_tag   (ex_tag[1]),
        .ex_mul_grant (ex_grant[1]),
        .ex_bch_valid (ex_valid[2]),
        .ex_bch_func  (ex_func[2]),
        .ex_bch_a     (ex_a[2]),
        .ex_bch_b     (ex_b[2]),
        .ex_bch_tag   (ex_tag[2]),
        .ex_bch_grant (ex_grant[2]),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .commit_wr    (commit_wr)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // 0 add/sub, 1 mul/mulh, 2 branch compare
    function automatic int func_class(input func_t f);
        if (f < 4'd2)
            return 0;
        else if (f < 4'd4)
            return 1;
        return 2;
    endfunction

    function automatic string class_name(input int c);
        case (c)
            0:       return "add";
            1:       return "mul";
            default: return "bch";
        endcase
    endfunction

    function automatic word_t unit_result(input func_t f, input word_t a, input word_t b);
        logic [31:0] p;
        p = {16'd0, a} * {16'd0, b};
        case (f)
            fn_add:  return a + b;
            fn_sub:  return a - b;
            fn_mul:  return p[15:0];
            fn_mulh: return p[31:16];
            default: return (a == b) ? 16'd1 : 16'd0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected == actual)
        else
        begin
            errors++;
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // an offer withheld from its unit must not change
    for (genvar c = 0; c < 3; c++)
    begin : g_offer
        offer_held: assert property (@(posedge clk1) disable iff (rst)
            ex_valid[c] && !ex_grant[c] |=>
                ex_valid[c] && $stable({ex_func[c], ex_a[c], ex_b[c], ex_tag[c]}))
        else
        begin
            errors++;
            $display("execute port %0d changed its offer before the grant", c);
        end
    end

    task automatic new_instr();
        logic [2:0] kind;
        seed = xorshift(seed);
        kind = seed[18:16];
        cur_salt = '0;
        if (generated < n_seed)
        begin
            // first pass loads a random word into each register
            cur_func = fn_add;
            cur_rd   = reg_idx_t'(generated);
            cur_rs1  = '0;
            cur_rs2  = '0;
            cur_salt = seed[31:16];
        end
        else
        begin
            if (kind < 3'd3)
                cur_func = {3'b000, seed[19]};
            else if (kind < 3'd6)
                cur_func = {3'b001, seed[19]};
            else
                cur_func = {1'b0, seed[22:20]} + 4'd4;
            // few registers so chains form often
            cur_rd  = {1'b0, seed[6:4]};
            cur_rs1 = {1'b0, seed[10:8]};
            cur_rs2 = {1'b0, seed[14:12]};
        end
        have_cur = 1'b1;
        generated++;
    endtask

    task automatic drive_inputs();
        int pick;
        if (!have_cur && generated < n_instr)
            new_instr();
        seed = xorshift(seed);
        in_valid = have_cur && seed[1:0] != 2'b00;
        in_func  = cur_func;
        in_rd    = cur_rd;
        in_rs1   = cur_rs1;
        in_rs2   = cur_rs2;
        for (int c = 0; c < 3; c++)
            ex_grant[c] = seed[4 + c] | seed[8 + c];
        pick = -1;
        // completions held back for a while so the buffer fills
        if ((cycle % 256) < 200)
        begin
            for (int i = 0; i < pend_tag.size(); i++)
            begin
                if (pick < 0 && pend_due[i] <= cycle)
                    pick = i;
            end
        end
        cdb_valid = pick >= 0;
        if (pick >= 0)
        begin
            cdb_tag   = pend_tag[pick];
            cdb_value = pend_val[pick];
            pend_tag.delete(pick);
            pend_val.delete(pick);
            pend_due.delete(pick);
        end
    endtask

    task automatic accept();
        rob_idx_t t;
        word_t    a;
        word_t    b;
        t = rob_idx_t'(issued);
        a = model_regs[in_rs1];
        b = model_regs[in_rs2];
        t_func[t]    = in_func;
        t_rd[t]      = in_rd;
        t_a[t]       = a;
        t_b[t]       = b;
        t_salt[t]    = cur_salt;
        t_res[t]     = unit_result(in_func, a, b) ^ cur_salt;
        t_granted[t] = 1'b0;
        if (func_class(in_func) != 2)
            model_regs[in_rd] = t_res[t];
        st_cnt[func_class(in_func)]++;
        issued++;
        have_cur = 1'b0;
    endtask

    task automatic execute(input int c);
        rob_idx_t t;
        t = ex_tag[c];
        check_value({class_name(c), " single grant"}, 0, t_granted[t]);
        check_value({class_name(c), " func"}, t_func[t], ex_func[c]);
        check_value({class_name(c), " operand a"}, t_a[t], ex_a[c]);
        check_value({class_name(c), " operand b"}, t_b[t], ex_b[c]);
        t_granted[t] = 1'b1;
        seed = xorshift(seed);
        pend_tag.push_back(t);
        pend_val.push_back(unit_result(ex_func[c], ex_a[c], ex_b[c]) ^ t_salt[t]);
        pend_due.push_back(cycle + 1 + int'(seed[2:0]));
        st_cnt[c]--;
    endtask

    task automatic retire();
        rob_idx_t t;
        t = rob_idx_t'(retired);
        assert (retired < issued)
        else
        begin
            errors++;
            $display("commit reported with no instruction in flight");
        end
        check_value("commit tag", t, commit_tag);
        check_value("commit rd", t_rd[t], commit_rd);
        check_value("commit wr", func_class(t_func[t]) != 2, commit_wr);
        check_value("commit value", t_res[t], commit_value);
        retired++;
    endtask

    // events that the coming edge will apply
    task automatic observe();
        int   cls;
        logic exp_stall;
        cls = func_class(in_func);
        exp_stall = ((issued - retired) == rob_depth) || (st_cnt[cls] == rs_depth);
        check_value("stall", exp_stall, stall);
        // the head leaves before this edge's issue enters
        if (commit_valid)
            retire();
        if (in_valid && !stall)
            accept();
        for (int c = 0; c < 3; c++)
        begin
            if (ex_valid[c] && ex_grant[c])
                execute(c);
        end
    endtask

    initial
    begin
        clk1 = 1'b0;
        forever #10 clk1 = ~clk1;
    end

    always @(posedge clk1)
    begin
        cycle <= cycle + 1;
        if (cycle == max_cycles)
        begin
            $display("timeout, %0d of %0d instructions retired after %0d cycles",
                     retired, n_instr, cycle);
            $display("Errors found");
            $finish;
        end
    end

    initial
    begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_func   = '0;
        in_rd     = '0;
        in_rs1    = '0;
        in_rs2    = '0;
        cdb_valid = 1'b0;
        cdb_tag   = '0;
        cdb_value = '0;
        for (int c = 0; c < 3; c++)
            ex_grant[c] = 1'b0;
        repeat (4) @(posedge clk1);
        #2;
        rst = 1'b0;
        #1;
        check_value("reset stall", 0, stall);
        check_value("reset commit", 0, commit_valid);
        for (int c = 0; c < 3; c++)
            check_value({class_name(c), " reset valid"}, 0, ex_valid[c]);
        while (retired < n_instr)
        begin
            @(posedge clk1);
            #2;
            drive_inputs();
            #1;
            observe();
        end
        $display("%0d checks, %0d errors, %0d instructions retired", checks, errors, retired);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/core_cfg_pkg.sv
verilog/op_pkg.sv
verilog/dispatch_if.sv
verilog/register_status.sv
verilog/reorder_buffer.sv
verilog/issue_stage.sv
verilog/reservation_station.sv
verilog/tomasulo_core.sv
sim/tomasulo_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tomasulo_tb
FILELIST = vlog.f

.PHONY: help test clean

help:
	@echo "help   list the targets"
	@echo "test   build and run the simulation, fail unless it passes"
	@echo "clean  remove the build output"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "No errors" > /dev/null

clean:
	rm -rf obj_dir
